//--- compile.f
source/vex_pkg.sv
source/bank_wr_if.sv
source/vector_bank.sv
source/bank_write_arbiter.sv
source/vlane_alu.sv
source/reduction_unit.sv
source/vex_result_stage.sv
source/vex_datapath.sv
testbench/tb_vex_datapath.sv

//--- source/bank_wr_if.sv
`timescale 1ns/1ps

interface bank_wr_if;
    import vex_pkg::*;

    // one cycle of valid is one write at that edge
    logic       valid;
    vreg_idx_t  vd;
    vlane_word_t wdata;
    vbyte_wen_t byte_wen;

    modport writer (
        output valid,
        output vd,
        output wdata,
        output byte_wen
    );

    modport bank (
        input valid,
        input vd,
        input wdata,
        input byte_wen
    );

endinterface

//--- source/bank_write_arbiter.sv
`timescale 1ns/1ps

module bank_write_arbiter (
    input  logic      CLK,
    input  logic      rst_n,
    bank_wr_if.bank   ld,
    bank_wr_if.bank   ex,
    bank_wr_if.writer bank
);
    import vex_pkg::*;

    logic        hold_valid;
    vreg_idx_t   hold_vd;
    vlane_word_t hold_wdata;
    vbyte_wen_t  hold_wen;
    logic        ex_park;

    // ex must wait when a load or an older held write owns the port
    assign ex_park = ex.valid && (ld.valid || hold_valid);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (ex_park) begin
            hold_valid <= 1'b1;
        end else if (!ld.valid) begin
            // slot drains whenever no load is present
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (ex_park) begin
            hold_vd    <= ex.vd;
            hold_wdata <= ex.wdata;
            hold_wen   <= ex.byte_wen;
        end
    end

    // load > held execute > fresh execute
    always_comb begin
        if (ld.valid) begin
            bank.valid    = 1'b1;
            bank.vd       = ld.vd;
            bank.wdata    = ld.wdata;
            bank.byte_wen = ld.byte_wen;
        end else if (hold_valid) begin
            bank.valid    = 1'b1;
            bank.vd       = hold_vd;
            bank.wdata    = hold_wdata;
            bank.byte_wen = hold_wen;
        end else begin
            bank.valid    = ex.valid;
            bank.vd       = ex.vd;
            bank.wdata    = ex.wdata;
            bank.byte_wen = ex.byte_wen;
        end
    end

    // issue spacing upstream should keep the slot free
    a_hold_free: assert property (@(posedge CLK) disable iff (!rst_n)
        ex.valid |-> !hold_valid)
        else $error("execute write arrived with hold slot full");

    // empty writes are filtered by the writers
    a_no_empty_wr: assert property (@(posedge CLK) disable iff (!rst_n)
        bank.valid |-> (|bank.byte_wen))
        else $error("bank write to v%0d with no byte enables", bank.vd);

endmodule

//--- source/reduction_unit.sv
`timescale 1ns/1ps

module reduction_unit (
    input  vex_pkg::valu_op_e   op,
    input  vex_pkg::word_t      seed,
    input  vex_pkg::vlane_word_t vdat,
    input  vex_pkg::lane_mask_t active,
    output vex_pkg::word_t      red_res
);
    import vex_pkg::*;

    word_t                  pad_word;
    vlane_word_t            padded;
    word_t [NUM_LANES:0]    acc;

    // identity of each op, so masked lanes drop out of the fold
    always_comb begin
        case (op)
            VALU_AND, VALU_MINU: begin
                pad_word = '1;
            end
            VALU_MIN: begin
                pad_word = 32'h7fff_ffff;
            end
            VALU_MAX: begin
                pad_word = 32'h8000_0000;
            end
            default: begin
                pad_word = '0;
            end
        endcase
    end

    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            padded[k] = active[k] ? vdat[k] : pad_word;
        end
    end

    assign acc[0] = seed;

    // serial fold, lane 0 first
    for (genvar k = 0; k < NUM_LANES; k++) begin : g_fold
        vlane_alu i_fold (
            .op     (op),
            .opa    (acc[k]),
            .opb    (padded[k]),
            .old_vd (acc[k]),
            .active (1'b1),
            .res    (acc[k+1])
        );
    end

    assign red_res = acc[NUM_LANES];

endmodule

//--- source/vector_bank.sv
`timescale 1ns/1ps

module vector_bank #(
    parameter int         NUM_REGS = 8,
    parameter logic [1:0] LANE     = 2'd0
) (
    input  logic              CLK,
    input  logic              rst_n,
    input  vex_pkg::vreg_idx_t rs1,
    input  vex_pkg::vreg_idx_t rs2,
    input  vex_pkg::vreg_idx_t rs3,
    bank_wr_if.bank           wr,
    output vex_pkg::word_t    rdat1,
    output vex_pkg::word_t    rdat2,
    output vex_pkg::word_t    rdat3,
    output vex_pkg::word_t    v0_elem
);
    import vex_pkg::*;

    localparam int IDX_W = $clog2(NUM_REGS);

    word_t            regs [NUM_REGS];
    logic [IDX_W-1:0] wr_idx;

    assign wr_idx = wr.vd[IDX_W-1:0];

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr.valid) begin
            // only this lane's slice of the vector write
            for (int b = 0; b < BYTES_W; b++) begin
                if (wr.byte_wen[LANE][b]) begin
                    regs[wr_idx][8*b +: 8] <= wr.wdata[LANE][8*b +: 8];
                end
            end
        end
    end

    // async reads
    assign rdat1   = regs[rs1[IDX_W-1:0]];
    assign rdat2   = regs[rs2[IDX_W-1:0]];
    assign rdat3   = regs[rs3[IDX_W-1:0]];
    assign v0_elem = regs[0];

    // writers must stay inside the bank depth
    a_wr_in_range: assert property (@(posedge CLK) disable iff (!rst_n)
        wr.valid |-> (int'(wr.vd) < NUM_REGS))
        else $error("bank %0d write to v%0d beyond depth", LANE, wr.vd);

endmodule

//--- source/vex_datapath.sv
`timescale 1ns/1ps

module vex_datapath #(
    parameter int NUM_REGS = 8
) (
    input  logic                 CLK,
    input  logic                 rst_n,
    // issue
    input  logic                 issue_valid,
    input  vex_pkg::valu_op_e    op,
    input  vex_pkg::vreg_idx_t   vs1,
    input  vex_pkg::vreg_idx_t   vs2,
    input  vex_pkg::vreg_idx_t   vd,
    input  logic                 use_scalar,
    input  vex_pkg::word_t       scalar_data,
    input  logic                 mask_en,
    input  logic                 is_reduction,
    // load writeback
    input  logic                 load_valid,
    input  vex_pkg::vreg_idx_t   load_vd,
    input  vex_pkg::vlane_word_t load_data,
    // result
    output logic                 res_valid,
    output vex_pkg::vlane_word_t res_data,
    output vex_pkg::lane_mask_t  res_lane_mask,
    output vex_pkg::vreg_idx_t   res_vd
);
    import vex_pkg::*;

    bank_wr_if ld_wr ();
    bank_wr_if ex_wr ();
    bank_wr_if bank_wr ();

    vlane_word_t src1;
    vlane_word_t src2;
    vlane_word_t old_vd;
    vlane_word_t v0_vec;
    vlane_word_t opb;
    vlane_word_t lane_res;
    word_t       red_res;
    opb_sel_e    opb_sel;
    lane_mask_t  lane_active;
    lane_mask_t  alu_active;

    // loads always cover the full vector
    assign ld_wr.valid    = load_valid;
    assign ld_wr.vd       = load_vd;
    assign ld_wr.wdata    = load_data;
    assign ld_wr.byte_wen = '1;

    assign opb_sel = use_scalar ? OPB_SCALAR : OPB_VREG;

    always_comb begin
        case (opb_sel)
            OPB_SCALAR: begin
                opb = {NUM_LANES{scalar_data}};
            end
            default: begin
                opb = src1;
            end
        endcase
    end

    // v0 bit 0 of each element gates its lane
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            lane_active[k] = !mask_en || v0_vec[k][0];
        end
    end

    // reductions leave the lanes showing old vd
    assign alu_active = lane_active & {NUM_LANES{!is_reduction}};

    for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
        vector_bank #(
            .NUM_REGS (NUM_REGS),
            .LANE     (2'(k))
        ) i_bank (
            .CLK     (CLK),
            .rst_n   (rst_n),
            .rs1     (vs1),
            .rs2     (vs2),
            .rs3     (vd),
            .wr      (bank_wr),
            .rdat1   (src1[k]),
            .rdat2   (src2[k]),
            .rdat3   (old_vd[k]),
            .v0_elem (v0_vec[k])
        );

        vlane_alu i_alu (
            .op     (op),
            .opa    (src2[k]),
            .opb    (opb[k]),
            .old_vd (old_vd[k]),
            .active (alu_active[k]),
            .res    (lane_res[k])
        );
    end

    reduction_unit i_reduction (
        .op      (op),
        .seed    (scalar_data),
        .vdat    (src2),
        .active  (lane_active),
        .red_res (red_res)
    );

    vex_result_stage i_result (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .is_reduction  (is_reduction),
        .vd            (vd),
        .lane_res      (lane_res),
        .red_res       (red_res),
        .active        (lane_active),
        .ex_wr         (ex_wr),
        .res_valid     (res_valid),
        .res_data      (res_data),
        .res_lane_mask (res_lane_mask),
        .res_vd        (res_vd)
    );

    bank_write_arbiter i_arbiter (
        .CLK   (CLK),
        .rst_n (rst_n),
        .ld    (ld_wr),
        .ex    (ex_wr),
        .bank  (bank_wr)
    );

endmodule

//--- source/vex_pkg.sv
package vex_pkg;

    // four lanes, one 32-bit bank each
    localparam int NUM_LANES  = 4;
    localparam int WORD_W     = 32;
    localparam int BYTES_W    = WORD_W / 8;
    localparam int VREG_IDX_W = 5;

    typedef logic [WORD_W-1:0] word_t;

    // banks decode only the low bits their depth needs
    typedef logic [VREG_IDX_W-1:0] vreg_idx_t;

    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // element k sits at bits [32k+31:32k]
    typedef word_t [NUM_LANES-1:0] vlane_word_t;

    // 4 byte enables per lane
    typedef logic [NUM_LANES-1:0][BYTES_W-1:0] vbyte_wen_t;

    typedef enum logic [3:0] {
        VALU_ADD  = 4'd0,
        VALU_SUB  = 4'd1,
        VALU_AND  = 4'd2,
        VALU_OR   = 4'd3,
        VALU_XOR  = 4'd4,
        VALU_MIN  = 4'd5,
        VALU_MAX  = 4'd6,
        VALU_MINU = 4'd7,
        VALU_MAXU = 4'd8,
        VALU_SEQ  = 4'd9,
        VALU_SLT  = 4'd10,
        VALU_SLTU = 4'd11
    } valu_op_e;

    // source of the vs1-side operand
    typedef enum logic {
        OPB_VREG   = 1'b0,
        OPB_SCALAR = 1'b1
    } opb_sel_e;

endpackage

//--- source/vex_result_stage.sv
`timescale 1ns/1ps

module vex_result_stage (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  logic                 is_reduction,
    input  vex_pkg::vreg_idx_t   vd,
    input  vex_pkg::vlane_word_t lane_res,
    input  vex_pkg::word_t       red_res,
    input  vex_pkg::lane_mask_t  active,
    bank_wr_if.writer            ex_wr,
    output logic                 res_valid,
    output vex_pkg::vlane_word_t res_data,
    output vex_pkg::lane_mask_t  res_lane_mask,
    output vex_pkg::vreg_idx_t   res_vd
);
    import vex_pkg::*;

    vlane_word_t next_data;
    lane_mask_t  next_mask;
    vbyte_wen_t  byte_wen;

    // on a reduction the lanes carry old vd, element 0 gets the fold
    always_comb begin
        next_data = lane_res;
        next_mask = active;
        if (is_reduction) begin
            next_data[0] = red_res;
            next_mask    = '0;
            next_mask[0] = 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= issue_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue_valid) begin
            res_data      <= next_data;
            res_lane_mask <= next_mask;
            res_vd        <= vd;
        end
    end

    // lane mask to byte enables
    always_comb begin
        for (int k = 0; k < NUM_LANES; k++) begin
            byte_wen[k] = {BYTES_W{res_lane_mask[k]}};
        end
    end

    // fully masked result still reports, but writes nothing
    assign ex_wr.valid    = res_valid && (|res_lane_mask);
    assign ex_wr.vd       = res_vd;
    assign ex_wr.wdata    = res_data;
    assign ex_wr.byte_wen = byte_wen;

endmodule

//--- source/vlane_alu.sv
`timescale 1ns/1ps

module vlane_alu (
    input  vex_pkg::valu_op_e op,
    input  vex_pkg::word_t    opa,
    input  vex_pkg::word_t    opb,
    input  vex_pkg::word_t    old_vd,
    input  logic              active,
    output vex_pkg::word_t    res
);
    import vex_pkg::*;

    logic  lt_s;
    logic  lt_u;
    logic  eq;
    word_t calc;

    // opa is the vs2 element, opb the vs1 element or scalar
    assign lt_s = $signed(opa) < $signed(opb);
    assign lt_u = opa < opb;
    assign eq   = opa == opb;

    always_comb begin
        case (op)
            VALU_ADD: begin
                calc = opa + opb;
            end
            VALU_SUB: begin
                calc = opa - opb;
            end
            VALU_AND: begin
                calc = opa & opb;
            end
            VALU_OR: begin
                calc = opa | opb;
            end
            VALU_XOR: begin
                calc = opa ^ opb;
            end
            VALU_MIN: begin
                calc = lt_s ? opa : opb;
            end
            VALU_MAX: begin
                calc = lt_s ? opb : opa;
            end
            VALU_MINU: begin
                calc = lt_u ? opa : opb;
            end
            VALU_MAXU: begin
                calc = lt_u ? opb : opa;
            end
            // compares produce 0 or 1 per element
            VALU_SEQ: begin
                calc = word_t'(eq);
            end
            VALU_SLT: begin
                calc = word_t'(lt_s);
            end
            VALU_SLTU: begin
                calc = word_t'(lt_u);
            end
            default: begin
                calc = '0;
            end
        endcase
    end

    // masked off lane keeps the old destination element
    assign res = active ? calc : old_vd;

endmodule

//--- testbench/tb_vex_datapath.sv
`timescale 1ns/1ps

module tb_vex_datapath;
    import vex_pkg::*;

    localparam int NUM_REGS = 8;

    // kind 0 load or 1 issue or 2 issue with a load in its result cycle
    typedef struct {
        int          kind;
        valu_op_e    op;
        int          vs1;
        int          vs2;
        int          vd;
        logic        mask_en;
        logic        use_scalar;
        logic        is_red;
        word_t       scalar;
        vlane_word_t data;
        lane_mask_t  exp_mask;
        int          ld_vd;
        vlane_word_t ld_data;
    } entry_t;

    logic        CLK;
    logic        rst_n;
    logic        issue_valid;
    valu_op_e    op;
    vreg_idx_t   vs1;
    vreg_idx_t   vs2;
    vreg_idx_t   vd;
    logic        use_scalar;
    word_t       scalar_data;
    logic        mask_en;
    logic        is_reduction;
    logic        load_valid;
    vreg_idx_t   load_vd;
    vlane_word_t load_data;
    logic        res_valid;
    vlane_word_t res_data;
    lane_mask_t  res_lane_mask;
    vreg_idx_t   res_vd;

    entry_t      table_q[$];
    vlane_word_t model [NUM_REGS];
    logic [31:0] lfsr_state = 32'hb1b7bbef;
    int          errors = 0;
    logic        table_ready = 1'b0;

    vex_datapath #(.NUM_REGS(NUM_REGS)) i_vex_datapath (.*);

    always #50 CLK = ~CLK;

    // taps x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] next_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic vlane_word_t random_vector();
        vlane_word_t v;
        for (int k = 0; k < NUM_LANES; k++) begin
            v[k] = next_bits(32);
        end
        return v;
    endfunction

    function automatic int pick_reg();
        return int'(next_bits(3) % 7) + 1;
    endfunction

    // a is the vs2 element and b the vs1 element or scalar
    function automatic word_t alu_model(valu_op_e f, word_t a, word_t b);
        case (f)
            VALU_ADD:  return a + b;
            VALU_SUB:  return a - b;
            VALU_AND:  return a & b;
            VALU_OR:   return a | b;
            VALU_XOR:  return a ^ b;
            VALU_MIN:  return ($signed(a) < $signed(b)) ? a : b;
            VALU_MAX:  return ($signed(a) < $signed(b)) ? b : a;
            VALU_MINU: return (a < b) ? a : b;
            VALU_MAXU: return (a < b) ? b : a;
            VALU_SEQ:  return (a == b) ? 32'd1 : 32'd0;
            VALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            VALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:   return '0;
        endcase
    endfunction

    task automatic queue_load(int d, vlane_word_t v);
        entry_t e;
        e.kind = 0;
        e.vd = d;
        e.data = v;
        model[d] = v;
        table_q.push_back(e);
    endtask

    task automatic expect_issue(int kind, valu_op_e f, int s1, int s2, int d, logic men,
                                logic usc, logic red, word_t sc, int lvd, vlane_word_t ldat);
        entry_t     e;
        lane_mask_t act;
        word_t      acc;
        word_t      b;
        for (int k = 0; k < NUM_LANES; k++) begin
            act[k] = !men || model[0][k][0];
        end
        e.data = model[d];
        if (red) begin
            // only active lanes join the fold
            acc = sc;
            for (int k = 0; k < NUM_LANES; k++) begin
                if (act[k]) begin
                    acc = alu_model(f, acc, model[s2][k]);
                end
            end
            e.data[0] = acc;
            e.exp_mask = 4'b0001;
        end else begin
            for (int k = 0; k < NUM_LANES; k++) begin
                b = usc ? sc : model[s1][k];
                if (act[k]) begin
                    e.data[k] = alu_model(f, model[s2][k], b);
                end
            end
            e.exp_mask = act;
        end
        e.kind = kind;
        e.op = f;
        e.vs1 = s1;
        e.vs2 = s2;
        e.vd = d;
        e.mask_en = men;
        e.use_scalar = usc;
        e.is_red = red;
        e.scalar = sc;
        e.ld_vd = lvd;
        e.ld_data = ldat;
        model[d] = e.data;
        if (kind == 2) begin
            model[lvd] = ldat;
        end
        table_q.push_back(e);
    endtask

    // OR with a zero scalar returns the register unchanged
    task automatic readback(int r);
        expect_issue(1, VALU_OR, 0, r, r, 1'b0, 1'b1, 1'b0, '0, 0, '0);
    endtask

    task automatic load_v0_pattern(lane_mask_t p);
        vlane_word_t v;
        v = random_vector();
        for (int k = 0; k < NUM_LANES; k++) begin
            v[k][0] = p[k];
        end
        queue_load(0, v);
    endtask

    task automatic build_table();
        lane_mask_t mpat [4] = '{4'b0101, 4'b1110, 4'b0011, 4'b1000};
        valu_op_e   rops [8] = '{VALU_ADD, VALU_AND, VALU_OR, VALU_XOR,
                                 VALU_MIN, VALU_MAX, VALU_MINU, VALU_MAXU};
        int         d;
        int         b;
        for (int r = 0; r < NUM_REGS; r++) begin
            queue_load(r, random_vector());
        end
        for (int r = 0; r < NUM_REGS; r++) begin
            readback(r);
        end
        for (int i = 0; i < 12; i++) begin
            expect_issue(1, valu_op_e'(i), pick_reg(), pick_reg(), pick_reg(), 1'b0,
                         i % 3 == 0, 1'b0, next_bits(32), 0, '0);
        end
        expect_issue(1, VALU_SEQ, 3, 3, 5, 1'b0, 1'b0, 1'b0, '0, 0, '0);
        // masked lane ops each followed by a readback of vd
        for (int i = 0; i < 3; i++) begin
            d = pick_reg();
            load_v0_pattern(mpat[i]);
            expect_issue(1, valu_op_e'(next_bits(4) % 12), pick_reg(), pick_reg(), d, 1'b1,
                         1'b0, 1'b0, '0, 0, '0);
            readback(d);
        end
        for (int i = 0; i < 8; i++) begin
            d = pick_reg();
            load_v0_pattern(i == 0 ? 4'b1111 : mpat[i % 4]);
            expect_issue(1, rops[i], 0, pick_reg(), d, 1'b1, 1'b0, 1'b1, next_bits(32), 0, '0);
            readback(d);
        end
        // load lands while the execute write is in flight
        for (int i = 0; i < 2; i++) begin
            d = pick_reg();
            b = (d % 7) + 1;
            expect_issue(2, VALU_ADD, pick_reg(), pick_reg(), d, 1'b0, 1'b0, 1'b0, '0,
                         b, random_vector());
            readback(d);
            readback(b);
        end
    endtask

    task automatic check_result(entry_t e);
        if (res_valid !== 1'b1) begin
            errors++;
            $display("[ERROR] %0t res_valid exp 1 got %b", $time, res_valid);
        end
        if (res_data !== e.data) begin
            errors++;
            $display("[ERROR] %0t res_data exp %h got %h", $time, e.data, res_data);
        end
        if (res_lane_mask !== e.exp_mask) begin
            errors++;
            $display("[ERROR] %0t res_lane_mask exp %b got %b", $time, e.exp_mask,
                     res_lane_mask);
        end
        if (res_vd !== vreg_idx_t'(e.vd)) begin
            errors++;
            $display("[ERROR] %0t res_vd exp %0d got %0d", $time, e.vd, res_vd);
        end
    endtask

    // four falling edges per entry
    task automatic apply_entry(entry_t e);
        @(negedge CLK);
        if (e.kind == 0) begin
            load_valid = 1'b1;
            load_vd = vreg_idx_t'(e.vd);
            load_data = e.data;
        end else begin
            issue_valid = 1'b1;
            op = e.op;
            vs1 = vreg_idx_t'(e.vs1);
            vs2 = vreg_idx_t'(e.vs2);
            vd = vreg_idx_t'(e.vd);
            mask_en = e.mask_en;
            use_scalar = e.use_scalar;
            is_reduction = e.is_red;
            scalar_data = e.scalar;
        end
        @(negedge CLK);
        issue_valid = 1'b0;
        load_valid = 1'b0;
        if (e.kind != 0) begin
            check_result(e);
        end
        if (e.kind == 2) begin
            load_valid = 1'b1;
            load_vd = vreg_idx_t'(e.ld_vd);
            load_data = e.ld_data;
        end
        @(negedge CLK);
        load_valid = 1'b0;
        if (res_valid !== 1'b0) begin
            errors++;
            $display("[ERROR] %0t res_valid exp 0 got %b", $time, res_valid);
        end
        @(negedge CLK);
    endtask

    initial begin
        CLK = 1'b0;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        op = VALU_ADD;
        vs1 = '0;
        vs2 = '0;
        vd = '0;
        use_scalar = 1'b0;
        scalar_data = '0;
        mask_en = 1'b0;
        is_reduction = 1'b0;
        load_valid = 1'b0;
        load_vd = '0;
        load_data = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model[r] = '0;
        end
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        $display("entries: %0d errors: %0d", table_q.size(), errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #((table_q.size() * 6 + 20) * 100);
        $display("watchdog expired before all entries were applied");
        $display("Test failures found");
        $finish;
    end

endmodule
